//--- design/lsu_config.svh
////////////////////////////////////////////////////////////////////////////
// Global sizing for the load/store unit
// Include this in any file that needs bus widths or the limit on
// outstanding bus transactions
////////////////////////////////////////////////////////////////////////////

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Bus geometry
////////////////////////////////////////////////////////////////////////////

// Byte address width of the data bus
`define LSU_ADDR_W 32

// One bus word
`define LSU_DATA_W 32

// One enable per byte lane
`define LSU_BE_W 4

////////////////////////////////////////////////////////////////////////////
// Pipelining
////////////////////////////////////////////////////////////////////////////

// Bus transactions that may be granted before their response arrives
`define LSU_MAX_OUTSTANDING 2

`endif

//--- design/lsu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the load/store unit
// Execute-side operation, bus request and response, per-transaction
// record and the returned result
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

  // Access size, same coding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    lsu_size_byte = 2'b00,
    lsu_size_half = 2'b01,
    lsu_size_word = 2'b10
  } lsu_size_e;

  // One memory operation from the execute stage
  typedef struct packed {
    logic                   we;      // Store when set
    lsu_size_e              size;
    logic                   sext;    // Sign extend load data
    logic [`LSU_ADDR_W-1:0] base;    // rs1
    logic [`LSU_ADDR_W-1:0] offset;  // Immediate
    logic [`LSU_DATA_W-1:0] wdata;   // rs2, not yet lane aligned
  } lsu_op_t;

  // Request toward the data memory
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;    // Word aligned on a second part
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_DATA_W-1:0] wdata;   // Already rotated into lanes
  } lsu_bus_req_t;

  // Response from the data memory
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] rdata;
    logic                   err;
  } lsu_bus_rsp_t;

  // Kept per granted transaction until its response returns
  typedef struct packed {
    logic      we;
    lsu_size_e size;
    logic      sext;
    logic [1:0] offset;              // Byte offset of the operation
    logic      last;                 // Low only on the first part of a split
  } lsu_txn_info_t;

  // One result per operation
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] rdata;   // Don't care for stores
    logic                   err;     // OR over all parts
  } lsu_result_t;

endpackage

`default_nettype wire

//--- design/lsu_request_gen.sv
////////////////////////////////////////////////////////////////////////////
// Execute-side half of the load/store unit
// Forms the address, splits accesses that cross a word, builds byte
// enables and lane-rotated store data, and drives the bus request
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_request_gen (
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  // Execute stage
  input  wire logic                  op_valid_i,
  input  wire lsu_pkg::lsu_op_t      op_i,
  output logic                       op_ready_o,

  // Bus request channel
  output logic                       bus_req_o,
  output lsu_pkg::lsu_bus_req_t      bus_req_data_o,
  input  wire logic                  bus_gnt_i,

  // Transaction record
  input  wire logic                  txn_full_i,
  output logic                       txn_push_o,
  output lsu_pkg::lsu_txn_info_t     txn_info_o
);

  import lsu_pkg::*;

  localparam int mask_w = 2 * `LSU_BE_W;      // Lanes of two adjacent words

  logic [`LSU_ADDR_W-1:0]   addr;             // Effective address
  logic [`LSU_ADDR_W-1:0]   next_word_addr;   // Word after addr, for second part
  logic [1:0]               addr_off;         // Byte within the word
  logic [`LSU_BE_W-1:0]     size_mask;        // Lanes of the access at offset 0
  logic [mask_w-1:0]        lane_mask;        // Lanes spread over two words
  logic [2*`LSU_DATA_W-1:0] wdata_dup;        // Doubled store data for rotation
  logic                     split_q;          // Second part in progress
  logic                     split_first;      // First part of a two-word access
  logic                     granted;          // Bus accepted this cycle

  ////////////////////////////////////////////////////////////////////////////
  // Address
  ////////////////////////////////////////////////////////////////////////////

  assign addr           = op_i.base + op_i.offset;
  assign addr_off       = addr[1:0];
  assign next_word_addr = {addr[`LSU_ADDR_W-1:2] + 1'b1, 2'b00};

  ////////////////////////////////////////////////////////////////////////////
  // Byte lanes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i.size)
      lsu_size_byte: size_mask = 4'b0001;
      lsu_size_half: size_mask = 4'b0011;
      default:       size_mask = 4'b1111;     // Word
    endcase
  end

  // Upper nibble holds whatever spills into the next word
  assign lane_mask = {{`LSU_BE_W{1'b0}}, size_mask} << addr_off;

  // Misaligned word, or halfword at offset 3
  assign split_first = op_valid_i && !split_q && (|lane_mask[mask_w-1:`LSU_BE_W]);

  // Rotate left by the byte offset, same rotation serves both parts
  assign wdata_dup = {op_i.wdata, op_i.wdata} << {addr_off, 3'b000};

  ////////////////////////////////////////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////////////////////////////////////////

  assign bus_req_o = op_valid_i && !txn_full_i;  // Held low while the record is full
  assign granted   = bus_req_o && bus_gnt_i;

  always_comb begin
    bus_req_data_o.addr  = split_q ? next_word_addr : addr;
    bus_req_data_o.we    = op_i.we;
    bus_req_data_o.be    = split_q ? lane_mask[mask_w-1:`LSU_BE_W]
                                   : lane_mask[`LSU_BE_W-1:0];
    bus_req_data_o.wdata = wdata_dup[2*`LSU_DATA_W-1:`LSU_DATA_W];
  end

  // Accept the op only once its last part is granted
  assign op_ready_o = granted && !split_first;

  // One record per granted transaction
  assign txn_push_o        = granted;
  assign txn_info_o.we     = op_i.we;
  assign txn_info_o.size   = op_i.size;
  assign txn_info_o.sext   = op_i.sext;
  assign txn_info_o.offset = addr_off;
  assign txn_info_o.last   = !split_first;

  // Split phase, dropped whenever the execute stage goes idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!op_valid_i) begin
      split_q <= 1'b0;
    end else if (granted) begin
      split_q <= split_first;                   // Set at first part, clear at second
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Both halves of a split are built from the same operation
  op_stable_a : assert property (@(posedge clk) disable iff (!rst_n)
    op_valid_i && !op_ready_o |=> $stable(op_i));

endmodule

`default_nettype wire

//--- design/lsu_txn_fifo.sv
////////////////////////////////////////////////////////////////////////////
// In-order record of bus transactions awaiting a response
// Pushed at each grant, popped at each response, and its fill level
// doubles as the outstanding-transaction count
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_txn_fifo (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  push_i,
  input  wire lsu_pkg::lsu_txn_info_t info_i,
  input  wire logic                  pop_i,
  output lsu_pkg::lsu_txn_info_t     head_o,   // Oldest outstanding record
  output logic                       full_o,   // Limit reached, no new request
  output logic                       busy_o    // Anything in flight
);

  import lsu_pkg::*;

  localparam int depth = `LSU_MAX_OUTSTANDING;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  lsu_txn_info_t    mem [depth];              // Record storage
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;                  // Outstanding transactions

  // Wrap explicitly so any depth works
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    ptr_inc = (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_i)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;          // Idle, or grant and response together
      endcase
    end
  end

  // Storage only
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= info_i;
    end
  end

  assign head_o = mem[rd_ptr_q];
  assign full_o = (count_q == cnt_w'(depth));
  assign busy_o = (count_q != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // A response with nothing granted means the bus broke ordering
  no_pop_empty_a : assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> (count_q != '0));

  // Request side must honour full_o
  no_push_full_a : assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> !full_o || pop_i);

endmodule

`default_nettype wire

//--- design/lsu_rdata_align.sv
////////////////////////////////////////////////////////////////////////////
// Response-side half of the load/store unit
// Joins the two words of a split load, shifts the addressed bytes down,
// extends them, and merges bus errors into a single result per operation
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_rdata_align (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   rvalid_i,
  input  wire lsu_pkg::lsu_bus_rsp_t  rsp_i,
  input  wire lsu_pkg::lsu_txn_info_t head_i,    // Record of the responding transaction
  output logic                        res_valid_o,
  output lsu_pkg::lsu_result_t        res_o
);

  import lsu_pkg::*;

  logic [`LSU_DATA_W-1:0]   first_rdata_q;      // Low word of a split load
  logic                     first_err_q;        // Error of the first part
  logic                     is_split;           // Operation spans two words
  logic [2*`LSU_DATA_W-1:0] rdata_full;
  logic [2*`LSU_DATA_W-1:0] rdata_aligned;      // Only low word is used
  logic [`LSU_DATA_W-1:0]   rdata_ext;

  // Same rule as the request side, rebuilt from the record
  assign is_split = ((head_i.size == lsu_size_word) && (head_i.offset != 2'b00)) ||
                    ((head_i.size == lsu_size_half) && (head_i.offset == 2'b11));

  ////////////////////////////////////////////////////////////////////////////
  // First part capture
  ////////////////////////////////////////////////////////////////////////////

  // Data word only matters for loads
  always_ff @(posedge clk) begin
    if (rvalid_i && !head_i.last && !head_i.we) begin
      first_rdata_q <= rsp_i.rdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_err_q <= 1'b0;
    end else if (rvalid_i && !head_i.last) begin
      first_err_q <= rsp_i.err;                 // Held until the second part returns
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Realign and extend
  ////////////////////////////////////////////////////////////////////////////

  // Unsplit: doubling lets the shift wrap the word around
  assign rdata_full = is_split ? {rsp_i.rdata, first_rdata_q}
                               : {rsp_i.rdata, rsp_i.rdata};

  assign rdata_aligned = rdata_full >> {head_i.offset, 3'b000};

  always_comb begin
    case (head_i.size)
      lsu_size_byte: rdata_ext = {{(`LSU_DATA_W-8){head_i.sext && rdata_aligned[7]}},
                                  rdata_aligned[7:0]};
      lsu_size_half: rdata_ext = {{(`LSU_DATA_W-16){head_i.sext && rdata_aligned[15]}},
                                  rdata_aligned[15:0]};
      default:       rdata_ext = rdata_aligned[`LSU_DATA_W-1:0];   // Word
    endcase
  end

  // Result only on the last part
  assign res_valid_o = rvalid_i && head_i.last;
  assign res_o.rdata = rdata_ext;
  assign res_o.err   = rsp_i.err || (is_split && first_err_q);

endmodule

`default_nettype wire

//--- design/lsu_top.sv
////////////////////////////////////////////////////////////////////////////
// Load/store unit top level
// Request generator feeds the bus and the transaction record, the
// aligner turns bus responses into one result per operation
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  // Execute stage
  input  wire logic                  op_valid_i,
  input  wire lsu_pkg::lsu_op_t      op_i,
  output logic                       op_ready_o,

  // Data bus
  output logic                       bus_req_o,
  output lsu_pkg::lsu_bus_req_t      bus_req_data_o,
  input  wire logic                  bus_gnt_i,
  input  wire logic                  bus_rvalid_i,
  input  wire lsu_pkg::lsu_bus_rsp_t bus_rsp_i,

  // Write-back
  output logic                       res_valid_o,
  output lsu_pkg::lsu_result_t       res_o,
  output logic                       busy_o
);

  import lsu_pkg::*;

  logic          txn_push;
  lsu_txn_info_t txn_info;                      // Record of the granted transaction
  lsu_txn_info_t txn_head;                      // Record of the responding one
  logic          txn_full;

  lsu_request_gen u_request_gen (
    .clk            (clk),
    .rst_n          (rst_n),
    .op_valid_i     (op_valid_i),
    .op_i           (op_i),
    .op_ready_o     (op_ready_o),
    .bus_req_o      (bus_req_o),
    .bus_req_data_o (bus_req_data_o),
    .bus_gnt_i      (bus_gnt_i),
    .txn_full_i     (txn_full),
    .txn_push_o     (txn_push),
    .txn_info_o     (txn_info)
  );

  // Responses are in order, so every rvalid retires the head
  lsu_txn_fifo u_txn_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .push_i (txn_push),
    .info_i (txn_info),
    .pop_i  (bus_rvalid_i),
    .head_o (txn_head),
    .full_o (txn_full),
    .busy_o (busy_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .rvalid_i    (bus_rvalid_i),
    .rsp_i       (bus_rsp_i),
    .head_i      (txn_head),
    .res_valid_o (res_valid_o),
    .res_o       (res_o)
  );

endmodule

`default_nettype wire

//--- test/lsu_checker.sv
////////////////////////////////////////////////////////////////////////////
// Checker for the load/store unit testbench
// Keeps a byte model of the window, predicts each result at acceptance,
// checks bus requests at grant and results in order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_checker (
  input wire logic                  clk,
  input wire logic                  rst_n,
  input wire logic                  op_valid_i,
  input wire lsu_pkg::lsu_op_t      op_i,
  input wire logic                  op_ready_i,
  input wire logic                  bus_req_i,
  input wire lsu_pkg::lsu_bus_req_t bus_req_data_i,
  input wire logic                  bus_gnt_i,
  input wire logic                  bus_rvalid_i,
  input wire logic                  res_valid_i,
  input wire lsu_pkg::lsu_result_t  res_i,
  input wire logic                  busy_i
);

  import lsu_pkg::*;

  // Predicted result of one accepted operation
  typedef struct packed {
    logic        we;
    logic [31:0] rdata;
    logic        err;
  } expect_t;

  logic [7:0] ref_mem [256];                    // Reference window contents
  expect_t    exp_q [$];
  int         err_cnt;
  int         n_accept;
  int         n_result;
  int         outstanding;                      // Granted, not yet answered
  logic       phase2;                           // First part of a split granted

  function automatic logic [7:0] init_byte(input int unsigned a);
    logic [7:0] b;
    b = 8'(a);
    return 8'((b * 8'd29) + 8'd7) ^ 8'ha5;
  endfunction

  // Lanes over two adjacent words, upper half spills into the next word
  function automatic logic [7:0] lanes_of(input lsu_op_t op);
    logic [31:0] eff;
    logic [7:0]  m;
    int unsigned n;
    eff = op.base + op.offset;
    n   = 1 << op.size;
    m   = '0;
    for (int i = 0; i < n; i++) begin
      m[int'(eff[1:0]) + i] = 1'b1;             // Operand byte i sits in lane off+i
    end
    return m;
  endfunction

  // Predict, then apply a store to the model
  task automatic accept_op(input lsu_op_t op);
    logic [31:0] eff;
    int unsigned idx;
    int unsigned n;
    expect_t     e;
    eff     = op.base + op.offset;
    idx     = eff[7:0];
    n       = 1 << op.size;
    e.we    = op.we;
    e.rdata = '0;
    e.err   = 1'b0;
    for (int i = 0; i < n; i++) begin
      e.rdata[8*i +: 8] = ref_mem[idx + i];
      if (idx + i >= 240) e.err = 1'b1;         // Error region
      if (op.we) ref_mem[idx + i] = op.wdata[8*i +: 8];
    end
    if (op.sext && n == 1) e.rdata = {{24{e.rdata[7]}}, e.rdata[7:0]};
    if (op.sext && n == 2) e.rdata = {{16{e.rdata[15]}}, e.rdata[15:0]};
    exp_q.push_back(e);
    n_accept++;
  endtask

  // Address, enables, direction and lane data of one granted part
  task automatic check_grant();
    logic [31:0] eff;
    logic [7:0]  m;
    logic [31:0] exp_addr;
    logic [3:0]  exp_be;
    int          k;
    eff      = op_i.base + op_i.offset;
    m        = lanes_of(op_i);
    exp_addr = phase2 ? {eff[31:2] + 30'd1, 2'b00} : eff;
    exp_be   = phase2 ? m[7:4] : m[3:0];
    if (bus_req_data_i.addr !== exp_addr || bus_req_data_i.be !== exp_be ||
        bus_req_data_i.we !== op_i.we) begin
      $display("** Error @%0t: bus addr %h be %b we %b, expected %h %b %b", $time,
               bus_req_data_i.addr, bus_req_data_i.be, bus_req_data_i.we,
               exp_addr, exp_be, op_i.we);
      err_cnt++;
    end
    for (int l = 0; l < 4; l++) begin
      k = (phase2 ? 4 : 0) + l - eff[1:0];      // Operand byte carried by lane l
      if (op_i.we && exp_be[l] && bus_req_data_i.wdata[8*l +: 8] !== op_i.wdata[8*k +: 8]) begin
        $display("** Error @%0t: store lane %0d holds %h, expected %h", $time, l,
                 bus_req_data_i.wdata[8*l +: 8], op_i.wdata[8*k +: 8]);
        err_cnt++;
      end
    end
    if (!phase2 && m[7:4] != 4'h0) phase2 = 1'b1;
  endtask

  initial begin
    for (int i = 0; i < 256; i++) ref_mem[i] = init_byte(i);
    err_cnt     = 0;
    n_accept    = 0;
    n_result    = 0;
    outstanding = 0;
    phase2      = 1'b0;
  end

  always @(posedge clk) begin
    expect_t e;
    logic    split_seen;                        // First part granted before this edge
    if (!rst_n) begin
      if (bus_req_i || res_valid_i || busy_i) begin
        $display("Outputs of the DUT are not idle during reset");
        err_cnt++;
      end
      phase2      = 1'b0;
      outstanding = 0;
    end else begin
      split_seen = phase2;
      if (bus_req_i && outstanding >= `LSU_MAX_OUTSTANDING) begin
        $display("Bus request raised with %0d transactions outstanding", outstanding);
        err_cnt++;
      end
      if (bus_req_i && bus_gnt_i) check_grant();
      if (op_ready_i && !(op_valid_i && bus_req_i && bus_gnt_i)) begin
        $display("op_ready_o high without a granted operation");
        err_cnt++;
      end
      if (op_valid_i && op_ready_i) begin
        if ((lanes_of(op_i) >> 4) != 8'h0 && !split_seen) begin
          $display("Split operation accepted with only one bus transaction");
          err_cnt++;
        end
        phase2 = 1'b0;
        accept_op(op_i);
      end
      if (res_valid_i) begin
        n_result++;
        if (exp_q.size() == 0) begin
          $display("Result returned with no operation outstanding");
          err_cnt++;
        end else begin
          e = exp_q.pop_front();
          if (res_i.err !== e.err || (!e.we && res_i.rdata !== e.rdata)) begin
            $display("** Error @%0t: result %h err %b, expected %h err %b", $time,
                     res_i.rdata, res_i.err, e.rdata, e.err);
            err_cnt++;
          end
        end
      end
      outstanding = outstanding + ((bus_req_i && bus_gnt_i) ? 1 : 0)
                                - (bus_rvalid_i ? 1 : 0);
    end
  end

endmodule

`default_nettype wire

//--- test/tb_lsu.sv
////////////////////////////////////////////////////////////////////////////
// Testbench top for the load/store unit
// Drives random loads and stores into a 256-byte window, answers the bus
// with a randomly delayed memory, and reports the checker's verdict
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

  import lsu_pkg::*;

  localparam int          num_ops  = 2000;
  localparam logic [31:0] win_base = 32'h0000_2000;  // 256-byte aligned window

  // Bus response waiting in the memory model
  typedef struct packed {
    logic [31:0] due;                           // Cycle at which rvalid is driven
    logic [31:0] rdata;
    logic        err;
  } pending_t;

  logic          clk;
  logic          rst_n;
  logic          op_valid;
  lsu_op_t       op;
  logic          op_ready;
  logic          bus_req;
  lsu_bus_req_t  bus_req_data;
  logic          bus_gnt;
  logic          bus_rvalid;
  lsu_bus_rsp_t  bus_rsp;
  logic          res_valid;
  lsu_result_t   res;
  logic          busy;

  integer        seed;
  logic [7:0]    bus_mem [256];                 // Memory behind the bus
  pending_t      rsp_q [$];                     // In-order responses
  logic [31:0]   cycle;
  logic [31:0]   last_due;
  int unsigned   gnt_delay;                     // Cycles left before next grant

  ////////////////////////////////////////////////////////////////////////////
  // Clock, DUT and checker
  ////////////////////////////////////////////////////////////////////////////

  initial clk = 1'b0;
  always #4 clk = ~clk;                         // 8 ns period

  lsu_top u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .op_valid_i     (op_valid),
    .op_i           (op),
    .op_ready_o     (op_ready),
    .bus_req_o      (bus_req),
    .bus_req_data_o (bus_req_data),
    .bus_gnt_i      (bus_gnt),
    .bus_rvalid_i   (bus_rvalid),
    .bus_rsp_i      (bus_rsp),
    .res_valid_o    (res_valid),
    .res_o          (res),
    .busy_o         (busy)
  );

  lsu_checker u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .op_valid_i     (op_valid),
    .op_i           (op),
    .op_ready_i     (op_ready),
    .bus_req_i      (bus_req),
    .bus_req_data_i (bus_req_data),
    .bus_gnt_i      (bus_gnt),
    .bus_rvalid_i   (bus_rvalid),
    .res_valid_i    (res_valid),
    .res_i          (res),
    .busy_i         (busy)
  );

  // Same whole-address pattern as the checker's model
  function automatic logic [7:0] init_byte(input int unsigned a);
    logic [7:0] b;
    b = 8'(a);
    return 8'((b * 8'd29) + 8'd7) ^ 8'ha5;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus memory responder
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    for (int i = 0; i < 256; i++) bus_mem[i] = init_byte(i);
    bus_gnt    = 1'b0;
    bus_rvalid = 1'b0;
    bus_rsp    = '0;
    cycle      = '0;
    last_due   = '0;
    gnt_delay  = 0;
  end

  always @(posedge clk) begin
    pending_t    p;
    logic [7:0]  widx;
    logic [31:0] word;
    cycle = cycle + 1;
    if (rst_n) begin
      if (bus_rvalid) void'(rsp_q.pop_front());   // Response just consumed
      if (bus_req && bus_gnt) begin
        widx = {bus_req_data.addr[7:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
          if (bus_req_data.we && bus_req_data.be[i])
            bus_mem[widx + 8'(i)] = bus_req_data.wdata[8*i +: 8];
          word[8*i +: 8] = bus_mem[widx + 8'(i)];
        end
        p.due = cycle + ({$random(seed)} % 3);       // Seen 1 to 3 cycles later
        if (p.due <= last_due) p.due = last_due + 1;  // Keep order, one per cycle
        last_due  = p.due;
        p.rdata   = word;
        p.err     = (bus_req_data.addr[7:4] == 4'hf); // Top 16 bytes of the window
        rsp_q.push_back(p);
        gnt_delay = {$random(seed)} % 4;
      end else if (bus_req && gnt_delay != 0) begin
        gnt_delay = gnt_delay - 1;
      end
    end
    #1;
    bus_gnt = rst_n && (gnt_delay == 0);
    if (rst_n && rsp_q.size() != 0 && rsp_q[0].due <= cycle) begin
      bus_rvalid    = 1'b1;
      bus_rsp.rdata = rsp_q[0].rdata;
      bus_rsp.err   = rsp_q[0].err;
    end else begin
      bus_rvalid = 1'b0;
      bus_rsp    = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] eff;
    logic [31:0] r;
    int unsigned nbytes;
    int unsigned gap;
    int unsigned sz;
    int unsigned drain;
    int          tb_errs;
    logic        accepted;
    seed     = 32'ha78e8725;
    tb_errs  = 0;
    rst_n    = 1'b0;
    op_valid = 1'b0;
    op       = '0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int n = 0; n < num_ops; n++) begin
      gap = {$random(seed)} % 4;                // Idle cycles between operations
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      sz      = {$random(seed)} % 3;
      nbytes  = 1 << sz;
      eff     = win_base + ({$random(seed)} % (257 - nbytes));  // Stays in window
      r       = $random(seed);
      op.we   = r[0];
      op.sext = r[1];
      op.size = lsu_size_e'(sz);
      op.base   = $random(seed);                // Any base, offset makes up the rest
      op.offset = eff - op.base;
      op.wdata  = $random(seed);
      op_valid  = 1'b1;
      do begin
        @(posedge clk);
        accepted = op_ready;
        #1;
      end while (!accepted);
      op_valid = 1'b0;
    end

    // Let outstanding transactions retire
    drain = 0;
    while (busy && drain < 100) begin
      @(posedge clk);
      #1;
      drain++;
    end
    repeat (4) @(posedge clk);
    if (busy) begin
      $display("busy_o still high after the run drained");
      tb_errs++;
    end
    if (u_chk.n_accept != u_chk.n_result) begin
      $display("Accepted operations and returned results do not match");
      tb_errs++;
    end
    $display("Errors: %0d checker, %0d testbench (%0d operations, %0d results)",
             u_chk.err_cnt, tb_errs, u_chk.n_accept, u_chk.n_result);
    if (u_chk.err_cnt == 0 && tb_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog, 40 cycles per operation plus reset
  initial begin
    #((num_ops * 40 + 8) * 8);
    $display("Watchdog expired, the run did not finish within %0d cycles", num_ops * 40);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+design
design/lsu_pkg.sv
design/lsu_request_gen.sv
design/lsu_txn_fifo.sv
design/lsu_rdata_align.sv
design/lsu_top.sv
test/lsu_checker.sv
test/tb_lsu.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the load/store unit simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lsu -f sim.f -o Vtb_lsu

obj_dir/Vtb_lsu 2>&1 | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
